// ==== src/cache_cfg_pkg.sv ====
/* address field layout and datapath widths of the direct-mapped cache
   imported wherever a field position or width is needed */
package cache_cfg_pkg;

  localparam int ADDR_W    = 16;  // byte address
  localparam int WORD_W    = 16;  // cpu word
  localparam int BEAT_W    = 32;  // memory beat
  localparam int LINE_W    = 64;  // four words, two beats

  localparam int NUM_LINES = 8;
  localparam int INDEX_W   = 3;
  localparam int TAG_W     = 10;

  // field positions in the byte address
  localparam int WORD_LSB  = 1;   // bits 2:1 pick the word
  localparam int INDEX_LSB = 3;   // bits 5:3 pick the line
  localparam int TAG_LSB   = 6;   // bits 15:6 are the tag

  // bit 2 of a memory address picks the beat inside a line
  localparam int BEAT_BIT  = INDEX_LSB - 1;

endpackage

// ==== src/cache_types_pkg.sv ====
/* payload types held in the cache arrays and the controller state encoding
   shared by the storage, merge and controller blocks */
package cache_types_pkg;

  import cache_cfg_pkg::*;

  // one tag store entry, 12 bits
  typedef struct packed {
    logic             valid;
    logic             dirty;  // line differs from memory
    logic [TAG_W-1:0] tag;
  } tag_entry_t;

  typedef logic [LINE_W-1:0] line_t;  // whole cache line
  typedef logic [WORD_W-1:0] word_t;  // cpu side word
  typedef logic [BEAT_W-1:0] beat_t;  // memory side beat

  // controller states
  typedef enum logic [2:0] {
    idle,
    compare_tag,
    write_back,   // dirty victim out, two beats
    refill_req,   // two read requests
    refill_wait   // two read responses
  } cache_state_t;

endpackage

// ==== src/cache_array_if.sv ====
/* bundle between the controller and one storage array
   entry_t picks the payload, tag entry or data line */
`timescale 1ns/1ps

interface cache_array_if #(
  parameter type entry_t = logic
);

  import cache_cfg_pkg::*;

  logic               we;     // write at the next edge
  logic [INDEX_W-1:0] index;  // line select for read and write
  entry_t             wdata;
  entry_t             rdata;  // combinational from index

  // controller side
  modport ctrl (
    output we, index, wdata,
    input  rdata
  );

  // storage side
  modport store (
    input  we, index, wdata,
    output rdata
  );

endinterface

// ==== src/cache_array.sv ====
/* one storage array of NUM_LINES entries, used for both tags and line data
   read is combinational from the index, write lands on the clock edge */
`timescale 1ns/1ps

module cache_array #(
  parameter type entry_t = logic
) (
  input logic          clk,
  input logic          rst,
  cache_array_if.store bus
);

  import cache_cfg_pkg::*;

  entry_t entries [NUM_LINES];

  assign bus.rdata = entries[bus.index];  // async read

  always_ff @(posedge clk) begin
    if (rst) begin
      // all zero so every tag reads invalid
      for (int i = 0; i < NUM_LINES; i++) begin
        entries[i] <= '0;
      end
    end else if (bus.we) begin
      entries[bus.index] <= bus.wdata;
    end
  end

endmodule

// ==== src/credit_counter.sv ====
/* memory request credit tracker for the cache
   spend on every request beat, regain one per mem_credit pulse */
`timescale 1ns/1ps

module credit_counter #(
  parameter int MEM_CREDITS = 2
) (
  input  logic clk,
  input  logic rst,
  input  logic credit_spend,  // request beat issued this cycle
  input  logic mem_credit,    // memory freed a queue slot
  output logic credit_avail
);

  localparam int CNT_W = $clog2(MEM_CREDITS + 1);

  logic [CNT_W-1:0] count;

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= CNT_W'(MEM_CREDITS);  // full allowance
    end else begin
      case ({credit_spend, mem_credit})
        2'b10:   count <= count - 1'b1;
        2'b01:   count <= count + 1'b1;
        default: count <= count;  // both or neither, no change
      endcase
    end
  end

  assign credit_avail = (count != '0);

endmodule

// ==== src/line_merge.sv ====
/* line datapath of the cache: refill assembly, cpu word insert and extract,
   and the beat select for write-back requests */
`timescale 1ns/1ps

module line_merge (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              load_low,   // first refill response
  input  logic                              merge_sel,  // 1 refill line, 0 word insert
  input  logic                              beat_sel,   // write-back beat
  input  cache_types_pkg::beat_t            mem_resp_data,
  input  logic [cache_cfg_pkg::ADDR_W-1:0]  cpu_req_addr,
  input  cache_types_pkg::word_t            cpu_req_data,
  input  cache_types_pkg::line_t            line_rd,
  output cache_types_pkg::line_t            line_wr,
  output cache_types_pkg::word_t            cpu_res_data,
  output cache_types_pkg::beat_t            mem_req_data
);

  import cache_cfg_pkg::*;
  import cache_types_pkg::*;

  beat_t                             low_beat;  // line bits 31:0 during refill
  line_t                             inserted;
  logic [INDEX_LSB-WORD_LSB-1:0]     word_sel;

  assign word_sel = cpu_req_addr[INDEX_LSB-1:WORD_LSB];

  // holds beat 0 until beat 1 arrives
  always_ff @(posedge clk) begin
    if (rst) begin
      low_beat <= '0;
    end else if (load_low) begin
      low_beat <= mem_resp_data;
    end
  end

  // write hit, replace one word
  always_comb begin
    inserted = line_rd;
    inserted[word_sel*WORD_W +: WORD_W] = cpu_req_data;
  end

  assign line_wr      = merge_sel ? {mem_resp_data, low_beat} : inserted;
  assign cpu_res_data = line_rd[word_sel*WORD_W +: WORD_W];
  assign mem_req_data = beat_sel ? line_rd[BEAT_W +: BEAT_W] : line_rd[0 +: BEAT_W];

endmodule

// ==== src/cache_fsm.sv ====
/* cache controller: tag compare, write-back of dirty victims and refill
   drives both array bundles, the merge selects and credited memory requests */
`timescale 1ns/1ps

module cache_fsm (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             cpu_req_valid,
  input  logic                             cpu_req_write,
  input  logic [cache_cfg_pkg::ADDR_W-1:0] cpu_req_addr,
  output logic                             cpu_res_ready,
  cache_array_if.ctrl                      tag_if,
  cache_array_if.ctrl                      data_if,   // wdata comes from line_merge
  input  logic                             credit_avail,
  output logic                             credit_spend,
  input  logic                             mem_resp_valid,
  output logic                             mem_req_valid,
  output logic                             mem_req_write,
  output logic [cache_cfg_pkg::ADDR_W-1:0] mem_req_addr,
  output logic                             merge_sel,
  output logic                             beat_sel,
  output logic                             load_low
);

  import cache_cfg_pkg::*;
  import cache_types_pkg::*;

  cache_state_t       state, state_d;
  logic               req_beat, req_beat_d;    // next request beat
  logic               resp_beat, resp_beat_d;  // next response beat
  logic               ready_d;
  logic [TAG_W-1:0]   req_tag;
  logic [INDEX_W-1:0] req_index;
  tag_entry_t         tag_rd;
  tag_entry_t         tag_wr;
  logic               hit;

  assign req_tag   = cpu_req_addr[TAG_LSB +: TAG_W];
  assign req_index = cpu_req_addr[INDEX_LSB +: INDEX_W];
  assign tag_rd    = tag_if.rdata;
  assign hit       = tag_rd.valid && (tag_rd.tag == req_tag);

  // direct mapped, both arrays always look at the request line
  assign tag_if.index  = req_index;
  assign data_if.index = req_index;
  assign tag_if.wdata  = tag_wr;

  assign credit_spend = mem_req_valid;  // one credit per beat
  assign beat_sel     = req_beat;

  always_comb begin
    state_d       = state;
    req_beat_d    = req_beat;
    resp_beat_d   = resp_beat;
    ready_d       = 1'b0;
    tag_if.we     = 1'b0;
    tag_wr        = tag_rd;
    data_if.we    = 1'b0;
    mem_req_valid = 1'b0;
    mem_req_write = 1'b0;
    mem_req_addr  = {req_tag, req_index, req_beat, 2'b00};  // refill address
    merge_sel     = 1'b0;
    load_low      = 1'b0;

    case (state)
      idle: begin
        // ready still high means the request just served is still held
        if (cpu_req_valid && !cpu_res_ready) begin
          state_d = compare_tag;
        end
      end

      compare_tag: begin
        req_beat_d  = 1'b0;
        resp_beat_d = 1'b0;
        if (hit) begin
          ready_d = 1'b1;  // seen by cpu next cycle
          state_d = idle;
          if (cpu_req_write) begin
            data_if.we   = 1'b1;  // merged line from line_merge
            tag_if.we    = 1'b1;
            tag_wr.dirty = 1'b1;
          end
        end else if (tag_rd.valid && tag_rd.dirty) begin
          state_d = write_back;
        end else begin
          state_d = refill_req;  // invalid or clean victim
        end
      end

      write_back: begin
        // victim goes to the old tag's address
        mem_req_addr = {tag_rd.tag, req_index, req_beat, 2'b00};
        if (credit_avail) begin
          mem_req_valid = 1'b1;
          mem_req_write = 1'b1;
          req_beat_d    = ~req_beat;
          if (req_beat) begin
            state_d = refill_req;
          end
        end
      end

      refill_req: begin
        if (credit_avail) begin
          mem_req_valid = 1'b1;
          req_beat_d    = ~req_beat;
          if (req_beat) begin
            state_d = refill_wait;
          end
        end
      end

      refill_wait: begin
        if (mem_resp_valid && resp_beat) begin
          // second beat, write the whole line, valid and clean
          data_if.we   = 1'b1;
          merge_sel    = 1'b1;
          tag_if.we    = 1'b1;
          tag_wr.valid = 1'b1;
          tag_wr.dirty = 1'b0;
          tag_wr.tag   = req_tag;
          resp_beat_d  = 1'b0;
          state_d      = compare_tag;  // re-compare, write miss merges here
        end
      end

      default: state_d = idle;
    endcase

    // beat 0 may come back while beat 1 still waits for a credit
    if ((state == refill_req || state == refill_wait) && mem_resp_valid && !resp_beat) begin
      load_low    = 1'b1;
      resp_beat_d = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= idle;
      req_beat      <= 1'b0;
      resp_beat     <= 1'b0;
      cpu_res_ready <= 1'b0;
    end else begin
      state         <= state_d;
      req_beat      <= req_beat_d;
      resp_beat     <= resp_beat_d;
      cpu_res_ready <= ready_d;  // one cycle pulse
    end
  end

endmodule

// ==== src/cache_top.sv ====
/* write-back direct-mapped data cache between a 16-bit cpu port and a 32-bit
   credited memory port, instances and wiring only */
`timescale 1ns/1ps

module cache_top #(
  parameter int MEM_CREDITS = 2
) (
  input  logic                             clk,
  input  logic                             rst,
  // cpu side, held until cpu_res_ready
  input  logic                             cpu_req_valid,
  input  logic                             cpu_req_write,
  input  logic [cache_cfg_pkg::ADDR_W-1:0] cpu_req_addr,
  input  cache_types_pkg::word_t           cpu_req_data,
  output logic                             cpu_res_ready,
  output cache_types_pkg::word_t           cpu_res_data,
  // memory side, one credit per request beat
  input  logic                             mem_credit,
  input  logic                             mem_resp_valid,
  input  cache_types_pkg::beat_t           mem_resp_data,
  output logic                             mem_req_valid,
  output logic                             mem_req_write,
  output logic [cache_cfg_pkg::ADDR_W-1:0] mem_req_addr,
  output cache_types_pkg::beat_t           mem_req_data
);

  import cache_types_pkg::*;

  logic credit_avail;
  logic credit_spend;
  logic merge_sel;
  logic beat_sel;
  logic load_low;

  cache_array_if #(.entry_t(tag_entry_t)) tag_if ();
  cache_array_if #(.entry_t(line_t))      data_if ();

  cache_array #(.entry_t(tag_entry_t)) tag_store (
    .clk (clk),
    .rst (rst),
    .bus (tag_if)
  );

  cache_array #(.entry_t(line_t)) data_store (
    .clk (clk),
    .rst (rst),
    .bus (data_if)
  );

  credit_counter #(.MEM_CREDITS(MEM_CREDITS)) i_credit_counter (
    .clk          (clk),
    .rst          (rst),
    .credit_spend (credit_spend),
    .mem_credit   (mem_credit),
    .credit_avail (credit_avail)
  );

  // data array write data always comes through here
  line_merge i_line_merge (
    .clk           (clk),
    .rst           (rst),
    .load_low      (load_low),
    .merge_sel     (merge_sel),
    .beat_sel      (beat_sel),
    .mem_resp_data (mem_resp_data),
    .cpu_req_addr  (cpu_req_addr),
    .cpu_req_data  (cpu_req_data),
    .line_rd       (data_if.rdata),
    .line_wr       (data_if.wdata),
    .cpu_res_data  (cpu_res_data),
    .mem_req_data  (mem_req_data)
  );

  cache_fsm i_cache_fsm (
    .clk            (clk),
    .rst            (rst),
    .cpu_req_valid  (cpu_req_valid),
    .cpu_req_write  (cpu_req_write),
    .cpu_req_addr   (cpu_req_addr),
    .cpu_res_ready  (cpu_res_ready),
    .tag_if         (tag_if),
    .data_if        (data_if),
    .credit_avail   (credit_avail),
    .credit_spend   (credit_spend),
    .mem_resp_valid (mem_resp_valid),
    .mem_req_valid  (mem_req_valid),
    .mem_req_write  (mem_req_write),
    .mem_req_addr   (mem_req_addr),
    .merge_sel      (merge_sel),
    .beat_sel       (beat_sel),
    .load_low       (load_low)
  );

endmodule

// ==== sim/clock_gen.sv ====
/* testbench clock and reset, 40 ns period, reset held for 5 rising edges */
`timescale 1ns/1ps

module clock_gen #(
  parameter int HALF_PERIOD  = 20,
  parameter int RESET_CYCLES = 5
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #2 rst = 1'b0;  // released off the edge like other inputs
  end

endmodule

// ==== sim/mem_model.sv ====
/* memory behind the cache in the testbench: credit-limited request queue,
   in-order read answers, rule data for words never written */
`timescale 1ns/1ps

module mem_model #(
  parameter int          MEM_CREDITS = 2,
  parameter int unsigned SEED        = 32'hfa1f7365
) (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             mem_req_valid,
  input  logic                             mem_req_write,
  input  logic [cache_cfg_pkg::ADDR_W-1:0] mem_req_addr,
  input  cache_types_pkg::beat_t           mem_req_data,
  output logic                             mem_credit,
  output logic                             mem_resp_valid,
  output cache_types_pkg::beat_t           mem_resp_data,
  output int                               overruns
);

  import cache_cfg_pkg::*;
  import cache_types_pkg::*;

  localparam int DRIVE_DLY = 2;

  logic              q_write [$];  // request queue, one entry per beat
  logic [ADDR_W-1:0] q_addr [$];
  beat_t             q_data [$];
  logic [15:0]       words [int];  // written words by word address
  int                delay;        // cycles left before the head is served

  function automatic logic [15:0] word_at(input int wa);
    if (words.exists(wa)) begin
      return words[wa];
    end
    return 16'(wa) ^ 16'h5a5a;  // never written
  endfunction

  // answer or store the head entry, then free its slot
  task automatic serve_head();
    int wa;
    wa = int'(q_addr[0][ADDR_W-1:1]);
    if (q_write[0]) begin
      words[wa]     = q_data[0][15:0];   // low word at the beat address
      words[wa + 1] = q_data[0][31:16];
    end else begin
      mem_resp_valid = 1'b1;
      mem_resp_data  = {word_at(wa + 1), word_at(wa)};
    end
    mem_credit = 1'b1;
    void'(q_write.pop_front());
    void'(q_addr.pop_front());
    void'(q_data.pop_front());
  endtask

  initial begin
    void'($urandom(SEED));
    mem_credit     = 1'b0;
    mem_resp_valid = 1'b0;
    mem_resp_data  = '0;
    overruns       = 0;
    delay          = 0;
    forever begin
      @(posedge clk);
      #(DRIVE_DLY);
      mem_credit     = 1'b0;  // pulses, one cycle each
      mem_resp_valid = 1'b0;
      if (!rst && q_addr.size() != 0) begin
        if (delay != 0) begin
          delay--;
        end else begin
          serve_head();
          delay = int'($urandom_range(3, 0));  // gap before the next entry
        end
      end
      @(negedge clk);  // request lines settled mid-cycle
      if (!rst && mem_req_valid) begin
        q_write.push_back(mem_req_write);
        q_addr.push_back(mem_req_addr);
        q_data.push_back(mem_req_data);
        // uncredited requests are exactly the queued ones
        assert (q_addr.size() <= MEM_CREDITS) else begin
          overruns++;
          $display("credit overrun at %0t: %0d requests uncredited, limit %0d",
                   $time, q_addr.size(), MEM_CREDITS);
        end
      end
    end
  end

endmodule

// ==== sim/cache_tb.sv ====
/* testbench for the direct-mapped write-back cache, runs a table of cpu
   operations against a shadow memory and tag model and reports per row */
`timescale 1ns/1ps

module cache_tb;

  import cache_cfg_pkg::*;
  import cache_types_pkg::*;

  localparam int MEM_CREDITS = 2;
  localparam int N_ROWS      = 19;
  localparam int DRIVE_DLY   = 2;  // ns after the rising edge

  logic              clk;
  logic              rst;
  logic              cpu_req_valid;
  logic              cpu_req_write;
  logic [ADDR_W-1:0] cpu_req_addr;
  word_t             cpu_req_data;
  logic              cpu_res_ready;
  word_t             cpu_res_data;
  logic              mem_credit;
  logic              mem_resp_valid;
  beat_t             mem_resp_data;
  logic              mem_req_valid;
  logic              mem_req_write;
  logic [ADDR_W-1:0] mem_req_addr;
  beat_t             mem_req_data;
  int                overruns;

  // stimulus table with expected columns from predict_rows
  logic              op_write [N_ROWS];
  logic [ADDR_W-1:0] row_addr [N_ROWS];
  word_t             row_wdata [N_ROWS];
  word_t             exp_rdata [N_ROWS];
  logic              exp_hit [N_ROWS];
  int                exp_wb [N_ROWS];    // write-back beats
  logic [ADDR_W-1:0] wb_base [N_ROWS];   // victim line byte address
  line_t             wb_line [N_ROWS];   // victim contents

  // shadow state
  word_t             shadow_mem [int];
  logic              ref_valid [NUM_LINES];
  logic              ref_dirty [NUM_LINES];
  logic [9:0]        ref_tag [NUM_LINES];

  int n_set       = 0;
  int cur_row     = 0;
  int errors      = 0;
  int checks      = 0;
  int beats_total = 0;  // memory beats seen by the monitor
  int wb_total    = 0;
  int wb_errors   = 0;

  clock_gen i_clock_gen (
    .clk (clk),
    .rst (rst)
  );

  mem_model #(.MEM_CREDITS(MEM_CREDITS)) i_mem_model (
    .clk            (clk),
    .rst            (rst),
    .mem_req_valid  (mem_req_valid),
    .mem_req_write  (mem_req_write),
    .mem_req_addr   (mem_req_addr),
    .mem_req_data   (mem_req_data),
    .mem_credit     (mem_credit),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp_data  (mem_resp_data),
    .overruns       (overruns)
  );

  cache_top #(.MEM_CREDITS(MEM_CREDITS)) i_cache_top (
    .clk            (clk),
    .rst            (rst),
    .cpu_req_valid  (cpu_req_valid),
    .cpu_req_write  (cpu_req_write),
    .cpu_req_addr   (cpu_req_addr),
    .cpu_req_data   (cpu_req_data),
    .cpu_res_ready  (cpu_res_ready),
    .cpu_res_data   (cpu_res_data),
    .mem_credit     (mem_credit),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp_data  (mem_resp_data),
    .mem_req_valid  (mem_req_valid),
    .mem_req_write  (mem_req_write),
    .mem_req_addr   (mem_req_addr),
    .mem_req_data   (mem_req_data)
  );

  function automatic word_t ref_word(input int wa);
    if (shadow_mem.exists(wa)) begin
      return shadow_mem[wa];
    end
    return 16'(wa) ^ 16'h5a5a;  // unwritten memory rule
  endfunction

  task automatic add_row(input logic wr, input logic [ADDR_W-1:0] addr, input word_t data);
    op_write[n_set]  = wr;
    row_addr[n_set]  = addr;
    row_wdata[n_set] = data;
    n_set++;
  endtask

  task automatic load_table();
    add_row(1'b0, 16'h0000, 16'h0000);  // cold miss on index 0
    add_row(1'b0, 16'h0002, 16'h0000);  // hit in the same line
    add_row(1'b1, 16'h0004, 16'h1234);  // write hit makes the line dirty
    add_row(1'b0, 16'h0004, 16'h0000);
    add_row(1'b0, 16'h0006, 16'h0000);  // neighbour untouched
    add_row(1'b0, 16'h0040, 16'h0000);  // same index evicts the dirty line
    add_row(1'b0, 16'h0004, 16'h0000);  // written word back from memory
    add_row(1'b1, 16'h0088, 16'hbeef);  // write miss to an empty line
    add_row(1'b0, 16'h0088, 16'h0000);
    add_row(1'b0, 16'h008a, 16'h0000);
    add_row(1'b1, 16'h0448, 16'h0f0f);  // write miss over dirty line
    add_row(1'b0, 16'h0088, 16'h0000);
    add_row(1'b1, 16'hfff8, 16'ha5a5);  // top index and top tag
    add_row(1'b1, 16'hfffe, 16'h7777);  // last word of the line
    add_row(1'b0, 16'h7ff8, 16'h0000);
    add_row(1'b0, 16'hfffe, 16'h0000);
    add_row(1'b1, 16'h7ffc, 16'h3c3c);  // write miss over a clean valid line
    add_row(1'b0, 16'h7ffc, 16'h0000);  // merged word
    add_row(1'b0, 16'h7ffa, 16'h0000);  // refilled neighbour
  endtask

  // walks the table through the shadow model
  task automatic predict_rows();
    logic [2:0] idx;
    logic [9:0] tag;
    int         wa;
    for (int i = 0; i < NUM_LINES; i++) begin
      ref_valid[i] = 1'b0;
      ref_dirty[i] = 1'b0;
      ref_tag[i]   = '0;
    end
    for (int r = 0; r < N_ROWS; r++) begin
      idx        = row_addr[r][5:3];
      tag        = row_addr[r][15:6];
      wa         = int'(row_addr[r][15:1]);
      exp_hit[r] = ref_valid[idx] && (ref_tag[idx] == tag);
      exp_wb[r]  = 0;
      wb_base[r] = '0;
      wb_line[r] = '0;
      if (!exp_hit[r]) begin
        if (ref_valid[idx] && ref_dirty[idx]) begin
          exp_wb[r]  = 2;
          wb_base[r] = {ref_tag[idx], idx, 3'b000};
          for (int w = 0; w < 4; w++) begin
            wb_line[r][w*16 +: 16] = ref_word(int'(wb_base[r][15:1]) + w);
          end
        end
        ref_valid[idx] = 1'b1;  // refilled clean
        ref_tag[idx]   = tag;
        ref_dirty[idx] = 1'b0;
      end
      if (op_write[r]) begin
        shadow_mem[wa] = row_wdata[r];
        ref_dirty[idx] = 1'b1;
        exp_rdata[r]   = '0;
      end else begin
        exp_rdata[r] = ref_word(wa);
      end
    end
  endtask

  // write-back beats compared with the victim line
  always @(negedge clk) begin : watch_mem
    logic [ADDR_W-1:0] exp_addr;
    beat_t             exp_data;
    if (!rst && mem_req_valid) begin
      beats_total++;
      if (mem_req_write) begin
        exp_addr = {wb_base[cur_row][15:3], wb_total[0], 2'b00};  // beat 0 then 1
        exp_data = wb_total[0] ? wb_line[cur_row][63:32] : wb_line[cur_row][31:0];
        assert (exp_wb[cur_row] != 0 && mem_req_addr == exp_addr && mem_req_data == exp_data)
        else begin
          wb_errors++;
          $display("Fail %0t: write-back %h at %h, expected %h at %h",
                   $time, mem_req_data, mem_req_addr, exp_data, exp_addr);
        end
        wb_total++;
      end
    end
  end

  task automatic run_row(input int r);
    int    cycles;
    int    beats0;
    int    wb0;
    int    err0;
    word_t rdata;
    @(posedge clk);
    #(DRIVE_DLY);
    beats0        = beats_total;
    wb0           = wb_total;
    err0          = errors + wb_errors + overruns;
    cpu_req_valid = 1'b1;
    cpu_req_write = op_write[r];
    cpu_req_addr  = row_addr[r];
    cpu_req_data  = row_wdata[r];
    cycles        = 0;
    do begin
      @(posedge clk);
      #1;
      cycles++;
    end while (!cpu_res_ready);
    rdata = cpu_res_data;  // valid in the ready cycle
    #1;
    cpu_req_valid = 1'b0;
    checks += 2;
    if (!op_write[r]) begin
      checks++;
      assert (rdata == exp_rdata[r]) else begin
        errors++;
        $display("Fail %0t: read %h returned %h, expected %h",
                 $time, row_addr[r], rdata, exp_rdata[r]);
      end
    end
    assert (wb_total - wb0 == exp_wb[r]) else begin
      errors++;
      $display("Fail %0t: %0d write-back beats, expected %0d", $time, wb_total - wb0, exp_wb[r]);
    end
    // hit answers 2 cycles after valid with no memory traffic
    assert (exp_hit[r] ? (cycles == 2 && beats_total == beats0) : (cycles > 2)) else begin
      errors++;
      $display("Fail %0t: ready after %0d cycles with %0d beats, hit expected %0b",
               $time, cycles, beats_total - beats0, exp_hit[r]);
    end
    $display("row %0d %s %h: %s, %0d cycles", r, op_write[r] ? "write" : "read",
             row_addr[r], (errors + wb_errors + overruns == err0) ? "ok" : "error", cycles);
  endtask

  initial begin
    cpu_req_valid = 1'b0;
    cpu_req_write = 1'b0;
    cpu_req_addr  = '0;
    cpu_req_data  = '0;
    load_table();
    predict_rows();
    @(negedge rst);
    repeat (3) begin
      @(posedge clk);
      #1;
      checks++;
      assert (!cpu_res_ready && !mem_req_valid) else begin
        errors++;
        $display("Fail %0t: ready or memory request active before any request", $time);
      end
    end
    for (int r = 0; r < N_ROWS; r++) begin
      cur_row = r;
      run_row(r);
    end
    $display("%0d rows, %0d checks, %0d errors, %0d write-back errors, %0d credit overruns",
             N_ROWS, checks, errors, wb_errors, overruns);
    if (errors + wb_errors + overruns == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // watchdog allows 200 cycles per row
  initial begin
    repeat (N_ROWS * 200) @(posedge clk);
    $display("timeout: cache stopped answering at row %0d", cur_row);
    $display("Checks failed");
    $finish;
  end

endmodule

// ==== project.f ====
src/cache_cfg_pkg.sv
src/cache_types_pkg.sv
src/cache_array_if.sv
src/cache_array.sv
src/credit_counter.sv
src/line_merge.sv
src/cache_fsm.sv
src/cache_top.sv
sim/clock_gen.sv
sim/mem_model.sv
sim/cache_tb.sv

// ==== Makefile ====
# Verilator simulation of the cache testbench
TOP = cache_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f project.f -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir
